// File: rtl/revo_pkg.sv
`default_nettype none

package revo_pkg;

	// serial word framing, one bit per clock50 cycle
	localparam int word_bits = 8;
	localparam int bit_count_bits = $clog2(word_bits);

	// revolution length in word periods
	// kept short so a simulation covers many revolutions
	localparam int revo_period_words = 20;
	localparam int word_count_bits = $clog2(revo_period_words);

	// internal reset held this long after the external reset drops
	localparam int reset_hold_cycles = 32;
	localparam int hold_count_bits = $clog2(reset_hold_cycles + 1);

	// words shifted out on the two lanes
	localparam logic [word_bits-1:0] clock_pattern = 8'b1010_1010;
	localparam logic [word_bits-1:0] marker_word_on = 8'b1111_1111;
	localparam logic [word_bits-1:0] marker_word_off = 8'b0000_0000;

	// revolution flash length on the led
	localparam int led_stretch_cycles = 64;
	localparam int stretch_count_bits = $clog2(led_stretch_cycles + 1);

	// revolution counter shown on the low leds, wraps at 32
	localparam int revo_count_bits = 5;

	// led bus layout
	localparam int led_bits = 8;
	localparam int led_ready = 7;
	localparam int led_reset = 6;
	localparam int led_revo = 5;
	localparam int led_count_lsb = 0;

endpackage

`default_nettype wire

// File: rtl/reset_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer
	import revo_pkg::*;
(
	input wire clock50,
	input wire reset,
	output logic sys_reset
);

	// remaining hold cycles after the external reset falls
	logic [hold_count_bits-1:0] hold_count;
	logic hold_active;

	assign hold_active = (hold_count != '0);

	// counter reloads for as long as reset is high,
	// then runs down once reset is sampled low
	always_ff @(posedge clock50) begin
		if (reset) begin
			hold_count <= hold_count_bits'(reset_hold_cycles);
		end else if (hold_active) begin
			hold_count <= hold_count - 1'b1;
		end
	end

	// sys_reset follows the count value seen before the decrement,
	// so it drops on the edge where the counter is already zero
	always_ff @(posedge clock50) begin
		if (reset) begin
			sys_reset <= 1'b1;
		end else if (hold_active) begin
			sys_reset <= 1'b1;
		end else begin
			sys_reset <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/dual_lane_serializer.sv
`timescale 1ns/10ps
`default_nettype none

module dual_lane_serializer
	import revo_pkg::*;
(
	input wire clock50,
	input wire sys_reset,
	input wire [word_bits-1:0] marker_word,
	output logic word_tick,
	output logic clock_lane,
	output logic marker_lane
);

	// bit position inside the current word
	logic [bit_count_bits-1:0] bit_count;

	// shift registers for the two lanes
	logic [word_bits-1:0] clock_shift;
	logic [word_bits-1:0] marker_shift;

	localparam logic [bit_count_bits-1:0] last_bit =
		bit_count_bits'(word_bits - 1);

	// free-running bit counter frames the words
	always_ff @(posedge clock50) begin
		if (sys_reset) begin
			bit_count <= '0;
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// one cycle pulse on the last bit of each word
	assign word_tick = (bit_count == last_bit);

	// clock lane
	// reloads the fixed pattern at every word boundary
	always_ff @(posedge clock50) begin
		if (sys_reset) begin
			clock_shift <= '0;
		end else if (word_tick) begin
			clock_shift <= clock_pattern;
		end else begin
			clock_shift <= {clock_shift[word_bits-2:0], 1'b0};
		end
	end

	// marker lane
	// takes whatever word the generator holds at the tick
	always_ff @(posedge clock50) begin
		if (sys_reset) begin
			marker_shift <= '0;
		end else if (word_tick) begin
			marker_shift <= marker_word;
		end else begin
			marker_shift <= {marker_shift[word_bits-2:0], 1'b0};
		end
	end

	// msb first on both lanes
	assign clock_lane = clock_shift[word_bits-1];
	assign marker_lane = marker_shift[word_bits-1];

	// both registers are zero until the first load,
	// so the lanes stay low through reset and the first word period
	// a loaded word shows bit 7 in the cycle right after the tick edge

endmodule

`default_nettype wire

// File: rtl/revo_marker_generator.sv
`timescale 1ns/10ps
`default_nettype none

module revo_marker_generator
	import revo_pkg::*;
(
	input wire clock50,
	input wire sys_reset,
	input wire word_tick,
	output logic [word_bits-1:0] marker_word,
	output logic revo_marker
);

	// word periods left until the next revolution start
	logic [word_count_bits-1:0] word_count;
	logic revo_start;

	localparam logic [word_count_bits-1:0] word_count_reload =
		word_count_bits'(revo_period_words - 1);

	// the revolution begins on the tick where the count has run out
	assign revo_start = (word_count == '0);

	// word period down-counter
	always_ff @(posedge clock50) begin
		if (sys_reset) begin
			word_count <= word_count_reload;
		end else if (word_tick) begin
			if (revo_start) begin
				word_count <= word_count_reload;
			end else begin
				word_count <= word_count - 1'b1;
			end
		end
	end

	// marker word for the serializer
	// held for one full word period so the next tick samples it
	always_ff @(posedge clock50) begin
		if (sys_reset) begin
			marker_word <= marker_word_off;
		end else if (word_tick) begin
			if (revo_start) begin
				marker_word <= marker_word_on;
			end else begin
				marker_word <= marker_word_off;
			end
		end
	end

	// revolution level, high for the same word period
	always_ff @(posedge clock50) begin
		if (sys_reset) begin
			revo_marker <= 1'b0;
		end else if (word_tick) begin
			revo_marker <= revo_start;
		end
	end

	// first rise lands at the end of the 20th tick after reset,
	// and then repeats every revo_period_words ticks
	// the level stays up for word_bits cycles each time

endmodule

`default_nettype wire

// File: rtl/status_indicator.sv
`timescale 1ns/10ps
`default_nettype none

module status_indicator
	import revo_pkg::*;
(
	input wire clock50,
	input wire sys_reset,
	input wire word_tick,
	input wire revo_marker,
	output logic [led_bits-1:0] leds
);

	logic revo_marker_d;
	logic revo_rise;
	logic ready;
	logic [stretch_count_bits-1:0] stretch_count;
	logic [revo_count_bits-1:0] revo_count;
	logic revo_flash;

	// edge detect on the revolution level
	always_ff @(posedge clock50) begin
		if (sys_reset) begin
			revo_marker_d <= 1'b0;
		end else begin
			revo_marker_d <= revo_marker;
		end
	end

	assign revo_rise = revo_marker & ~revo_marker_d;

	// ready once the serializer has framed its first word
	always_ff @(posedge clock50) begin
		if (sys_reset) begin
			ready <= 1'b0;
		end else if (word_tick) begin
			ready <= 1'b1;
		end
	end

	// flash stretcher, retriggered by every revolution start
	always_ff @(posedge clock50) begin
		if (sys_reset) begin
			stretch_count <= '0;
		end else if (revo_rise) begin
			stretch_count <= stretch_count_bits'(led_stretch_cycles);
		end else if (stretch_count != '0) begin
			stretch_count <= stretch_count - 1'b1;
		end
	end

	assign revo_flash = (stretch_count != '0);

	// revolution count, wraps naturally
	always_ff @(posedge clock50) begin
		if (sys_reset) begin
			revo_count <= '0;
		end else if (revo_rise) begin
			revo_count <= revo_count + 1'b1;
		end
	end

	// led bus
	always_comb begin
		leds = '0;
		leds[led_ready] = ready;
		leds[led_reset] = sys_reset;
		leds[led_revo] = revo_flash;
		leds[led_count_lsb +: revo_count_bits] = revo_count;
	end

endmodule

`default_nettype wire

// File: rtl/revo_timing_top.sv
`timescale 1ns/10ps
`default_nettype none

module revo_timing_top
	import revo_pkg::*;
(
	input wire clock50,
	input wire reset,
	output logic clock_lane,
	output logic marker_lane,
	output logic revo_marker,
	output logic [led_bits-1:0] leds
);

	// internal reset, stretched past the external one
	wire sys_reset;

	// word framing strobe from the serializer
	wire word_tick;

	// word handed from the generator to the marker lane
	wire [word_bits-1:0] marker_word;

	reset_sequencer reset_sequencer_inst (
		.clock50(clock50),
		.reset(reset),
		.sys_reset(sys_reset)
	);

	// the serializer sets the word period for the whole chain
	dual_lane_serializer dual_lane_serializer_inst (
		.clock50(clock50),
		.sys_reset(sys_reset),
		.marker_word(marker_word),
		.word_tick(word_tick),
		.clock_lane(clock_lane),
		.marker_lane(marker_lane)
	);

	revo_marker_generator revo_marker_generator_inst (
		.clock50(clock50),
		.sys_reset(sys_reset),
		.word_tick(word_tick),
		.marker_word(marker_word),
		.revo_marker(revo_marker)
	);

	// leds read the revolution level straight off the top output
	status_indicator status_indicator_inst (
		.clock50(clock50),
		.sys_reset(sys_reset),
		.word_tick(word_tick),
		.revo_marker(revo_marker),
		.leds(leds)
	);

endmodule

`default_nettype wire

// File: tb/clock_source.sv
`timescale 1ns/10ps
`default_nettype none

module clock_source (
	output logic clock50
);

	// 100 ns period
	localparam int half_period_ns = 50;

	initial begin
		clock50 = 1'b0;
		forever begin
			#half_period_ns;
			clock50 = ~clock50;
		end
	end

endmodule

`default_nettype wire

// File: tb/revo_timing_tb.sv
`timescale 1ns/10ps
`default_nettype none

module revo_timing_tb
	import revo_pkg::*;
();

	localparam int clock_period_ns = 100;
	localparam int reset_cycles = 16;
	localparam int revo_cycles = revo_period_words * word_bits;

	// reset pulse, hold, and the edge where sys_reset drops
	localparam int restart_cycles = reset_cycles + reset_hold_cycles + 1;

	localparam int clock_lane_cycles = word_bits + 3 * revo_cycles;
	localparam int period_revs = 4;
	localparam int marker_revs = 4;
	localparam int status_revs = 34;
	localparam int status_cycles = status_revs * revo_cycles + led_stretch_cycles + word_bits;
	localparam int mid_reset_min = 200;
	localparam int mid_reset_span = 2048;
	localparam int mid_reset_revs = 2;

	localparam int total_cycles = restart_cycles
		+ (restart_cycles + clock_lane_cycles)
		+ (restart_cycles + period_revs * revo_cycles + 2 * word_bits)
		+ (restart_cycles + marker_revs * revo_cycles + 2 * word_bits)
		+ (restart_cycles + status_cycles)
		+ (2 * restart_cycles + mid_reset_min + mid_reset_span
			+ mid_reset_revs * revo_cycles + 2 * word_bits);
	localparam int watchdog_margin_cycles = 500;
	localparam int watchdog_cycles = total_cycles + watchdog_margin_cycles;

	localparam logic [31:0] lcg_seed = 32'hcf6e;
	localparam logic [led_bits-1:0] reset_only_leds = led_bits'(1) << led_reset;

	logic clock50;
	logic reset;
	logic clock_lane;
	logic marker_lane;
	logic revo_marker;
	logic [led_bits-1:0] leds;

	// cycles since sys_reset dropped, sampled just after each edge
	int window;
	logic [31:0] lcg_state;

	clock_source clock_source_inst (
		.clock50(clock50)
	);

	revo_timing_top revo_timing_top_inst (
		.clock50(clock50),
		.reset(reset),
		.clock_lane(clock_lane),
		.marker_lane(marker_lane),
		.revo_marker(revo_marker),
		.leds(leds)
	);

	task automatic end_with_failure(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_value_error(input string msg);
		end_with_failure($sformatf("[FAIL] %0t: %s", $time, msg));
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// inputs change and outputs are read 1 ns after the rising edge
	task automatic advance_cycle();
		@(posedge clock50);
		#1;
		window++;
	endtask

	// first word loads at the edge ending the first tick, bit 7 first
	function automatic logic clock_lane_bit(input int k);
		if (k < word_bits) begin
			return 1'b0;
		end
		return clock_pattern[word_bits - 1 - (k % word_bits)];
	endfunction

	// the tick after a rise ends word_bits cycles after it
	function automatic logic marker_lane_level(input int k);
		int phase;
		phase = k % revo_cycles;
		return (k >= revo_cycles) && (phase >= word_bits) && (phase < 2 * word_bits);
	endfunction

	task automatic expect_lanes_idle(input string phase);
		assert (clock_lane === 1'b0)
		else report_value_error($sformatf("clock_lane not low during %s", phase));
		assert (marker_lane === 1'b0)
		else report_value_error($sformatf("marker_lane not low during %s", phase));
		assert (revo_marker === 1'b0)
		else report_value_error($sformatf("revo_marker not low during %s", phase));
	endtask

	// pulse reset, check the hold, leave window at 0 where sys_reset is low
	task automatic run_reset_sequence();
		int i;
		reset = 1'b1;
		for (i = 1; i <= reset_cycles; i++) begin
			advance_cycle();
			// the blocks clear one edge after sys_reset is registered
			if (i >= 2) begin
				expect_lanes_idle("reset");
				assert (leds === reset_only_leds)
				else report_value_error($sformatf("leds are %b during reset", leds));
			end
		end
		reset = 1'b0;
		for (i = 1; i <= reset_hold_cycles; i++) begin
			advance_cycle();
			expect_lanes_idle("reset hold");
			assert (leds === reset_only_leds)
			else report_value_error($sformatf("leds are %b in hold cycle %0d", leds, i));
		end
		advance_cycle();
		expect_lanes_idle("release");
		assert (leds === '0)
		else report_value_error($sformatf("leds are %b after the hold ended", leds));
		window = 0;
	endtask

	task automatic verify_clock_lane();
		int i;
		logic expected;
		run_reset_sequence();
		for (i = 0; i < clock_lane_cycles; i++) begin
			advance_cycle();
			expected = clock_lane_bit(window);
			assert (clock_lane === expected)
			else report_value_error($sformatf("clock_lane is %b at cycle %0d, expected %b",
				clock_lane, window, expected));
		end
	endtask

	// measures rise spacing and high time from the current window 0
	task automatic measure_revolution_period(input int revs);
		int i;
		int next_rise;
		int last_rise;
		int rises;
		logic previous;
		previous = revo_marker;
		next_rise = revo_cycles;
		last_rise = 0;
		rises = 0;
		for (i = 0; i < revs * revo_cycles + 2 * word_bits; i++) begin
			advance_cycle();
			assert (!$isunknown(revo_marker))
			else report_value_error($sformatf("revo_marker unknown at cycle %0d", window));
			if (revo_marker && !previous) begin
				assert (window == next_rise)
				else report_value_error($sformatf("revo_marker rose at cycle %0d, expected %0d",
					window, next_rise));
				last_rise = window;
				next_rise += revo_cycles;
				rises++;
			end else if (!revo_marker && previous) begin
				assert (window - last_rise == word_bits)
				else report_value_error($sformatf("revo_marker high for %0d cycles, expected %0d",
					window - last_rise, word_bits));
			end
			previous = revo_marker;
		end
		assert (rises == revs)
		else report_value_error($sformatf("saw %0d revolutions, expected %0d", rises, revs));
	endtask

	task automatic check_revolution_timing();
		run_reset_sequence();
		measure_revolution_period(period_revs);
	endtask

	task automatic watch_marker_lane();
		int i;
		logic expected;
		run_reset_sequence();
		for (i = 0; i < marker_revs * revo_cycles + 2 * word_bits; i++) begin
			advance_cycle();
			expected = marker_lane_level(window);
			assert (marker_lane === expected)
			else report_value_error($sformatf("marker_lane is %b at cycle %0d, expected %b",
				marker_lane, window, expected));
		end
	endtask

	task automatic inspect_status_leds();
		int i;
		logic ready_expected;
		logic flash_expected;
		logic [revo_count_bits-1:0] count_expected;
		run_reset_sequence();
		for (i = 0; i < status_cycles; i++) begin
			advance_cycle();
			ready_expected = (window >= word_bits);
			// flash starts one cycle after each rise
			flash_expected = (window > revo_cycles)
				&& (((window - 1) % revo_cycles) < led_stretch_cycles);
			count_expected = revo_count_bits'(((window - 1) / revo_cycles)
				% (1 << revo_count_bits));
			assert (leds[led_ready] === ready_expected)
			else report_value_error($sformatf("ready led is %b at cycle %0d",
				leds[led_ready], window));
			assert (leds[led_reset] === 1'b0)
			else report_value_error($sformatf("reset led set at cycle %0d", window));
			assert (leds[led_revo] === flash_expected)
			else report_value_error($sformatf("revo led is %b at cycle %0d, expected %b",
				leds[led_revo], window, flash_expected));
			assert (leds[led_count_lsb +: revo_count_bits] === count_expected)
			else report_value_error($sformatf("count leds are %0d at cycle %0d, expected %0d",
				leds[led_count_lsb +: revo_count_bits], window, count_expected));
		end
	endtask

	task automatic apply_mid_run_reset();
		int i;
		int delay;
		logic [revo_count_bits-1:0] count_expected;
		run_reset_sequence();
		delay = mid_reset_min + int'((next_random() >> 8) % mid_reset_span);
		$display("mid-run reset after %0d cycles", delay);
		for (i = 0; i < delay; i++) begin
			advance_cycle();
		end
		count_expected = revo_count_bits'(((window - 1) / revo_cycles) % (1 << revo_count_bits));
		assert (leds[led_count_lsb +: revo_count_bits] === count_expected)
		else report_value_error($sformatf("count leds are %0d before the reset, expected %0d",
			leds[led_count_lsb +: revo_count_bits], count_expected));
		run_reset_sequence();
		measure_revolution_period(mid_reset_revs);
		// count restarts from zero
		assert (leds[led_count_lsb +: revo_count_bits] === revo_count_bits'(mid_reset_revs))
		else report_value_error($sformatf("count leds are %0d after the reset, expected %0d",
			leds[led_count_lsb +: revo_count_bits], mid_reset_revs));
	endtask

	initial begin : watchdog
		#(watchdog_cycles * clock_period_ns);
		end_with_failure("timeout: the tests did not finish in their expected run time");
	end

	initial begin
		reset = 1'b1;
		window = 0;
		lcg_state = lcg_seed;
		$timeformat(-9, 0, " ns", 0);
		run_reset_sequence();
		verify_clock_lane();
		check_revolution_timing();
		watch_marker_lane();
		inspect_status_leds();
		apply_mid_run_reset();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
rtl/revo_pkg.sv
rtl/reset_sequencer.sv
rtl/dual_lane_serializer.sv
rtl/revo_marker_generator.sv
rtl/status_indicator.sv
rtl/revo_timing_top.sv
tb/clock_source.sv
tb/revo_timing_tb.sv

// File: Makefile
# Verilator simulation of the revolution-marker timing generator

VERILATOR ?= verilator
TOP ?= revo_timing_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/10ps
JOBS ?= 0
VERILATOR_FLAGS ?= --binary --timing --assert --timescale $(TIMESCALE) -j $(JOBS)

.PHONY: sim clean

# the executable exits nonzero when the testbench calls $fatal
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
